// File: list.f
+incdir+verification
rtl/contra_rom_pkg.sv
rtl/contra_dwnld.sv
rtl/contra_rom_slot.sv
rtl/contra_rom_arb.sv
rtl/contra_main_map.sv
rtl/contra_rom_top.sv
verification/contra_rom_tb.sv

// File: rtl/contra_dwnld.sv
//==============================
// ROM download block
// ioctl bytes to SDRAM byte writes,
// PROM area bytes to prom_we pulses
//==============================

`timescale 1ns/1ps

module contra_dwnld #(
    parameter logic [24:0] prom_start = 25'h128_000
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        downloading,
    input  logic [24:0] ioctl_addr,
    input  logic [ 7:0] ioctl_data,
    input  logic        ioctl_wr,
    input  logic        sdram_ack,
    output logic [21:0] prog_addr,
    output logic [ 7:0] prog_data,
    output logic [ 1:0] prog_mask,  // Active low byte select
    output logic        prog_we,
    output logic        prom_we
);

    contra_rom_pkg::dwnld_state_e state;

    logic [24:0] prom_off;
    logic        is_prom;
    logic        take;

    assign is_prom  = ioctl_addr >= prom_start;
    assign prom_off = ioctl_addr - prom_start;
    // New bytes only accepted between SDRAM writes
    assign take     = downloading && ioctl_wr && state == contra_rom_pkg::dw_idle;
    assign prog_we  = state == contra_rom_pkg::dw_write;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= contra_rom_pkg::dw_idle;
            prom_we <= 1'b0;
        end else begin
            prom_we <= take && is_prom;  // One cycle only
            unique case (state)
                contra_rom_pkg::dw_idle: begin
                    if (take && !is_prom) state <= contra_rom_pkg::dw_write;
                end
                contra_rom_pkg::dw_write: begin
                    if (sdram_ack) state <= contra_rom_pkg::dw_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            prog_data <= ioctl_data;
            prog_mask <= ioctl_addr[0] ? 2'b01 : 2'b10;  // Odd byte goes high
            // PROM bytes keep their byte address relative to the PROM area
            prog_addr <= is_prom ? prom_off[21:0] : ioctl_addr[22:1];
        end
    end

    a_we_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(prog_we && prom_we))
        else $error("prog_we and prom_we high together");

endmodule

// File: rtl/contra_main_map.sv
//==============================
// Main CPU ROM map
// Bank register and ROM decode
//==============================

`timescale 1ns/1ps

module contra_main_map (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [15:0] cpu_addr,
    input  logic [ 7:0] cpu_dout,
    input  logic        bank_we,
    input  logic        cpu_rd,
    output logic [17:0] rom_addr,
    output logic        rom_cs
);

    logic [3:0] bank;
    logic       fixed_win;   // 8000-FFFF
    logic       bank_win;    // 6000-7FFF

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bank <= 4'd0;
        end else if (bank_we) begin
            bank <= cpu_dout[3:0];  // Upper bits ignored
        end
    end

    assign fixed_win = cpu_addr[15];
    assign bank_win  = cpu_addr[15:13] == 3'b011;

    // Banked pages sit above the fixed 32kB
    assign rom_addr = fixed_win ? {3'b000, cpu_addr[14:0]}
                                : {1'b1, bank, cpu_addr[12:0]};
    assign rom_cs   = cpu_rd && (fixed_win || bank_win);

endmodule

// File: rtl/contra_rom_arb.sv
//==============================
// SDRAM read arbiter
// Fixed priority gfx, snd, main
//==============================

`timescale 1ns/1ps

module contra_rom_arb (
    input  logic                                clk,
    input  logic                                rst_n,
    input  contra_rom_pkg::rom_req_t            gfx_req,
    input  contra_rom_pkg::rom_req_t            snd_req,
    input  contra_rom_pkg::rom_req_t            main_req,
    input  logic                                sdram_ack,
    input  logic                                data_rdy,
    input  logic [contra_rom_pkg::sdram_dw-1:0] data_read,
    output contra_rom_pkg::rom_resp_t           gfx_resp,
    output contra_rom_pkg::rom_resp_t           snd_resp,
    output contra_rom_pkg::rom_resp_t           main_resp,
    output logic                                sdram_req,
    output logic [contra_rom_pkg::sdram_aw-1:0] sdram_addr
);

    contra_rom_pkg::arb_state_e          state;
    contra_rom_pkg::slot_id_e            sel;
    contra_rom_pkg::slot_id_e            win;
    logic [contra_rom_pkg::sdram_aw-1:0] win_addr;
    logic                                rdy_hit;

    // Winner among the pending requests
    always_comb begin
        win      = contra_rom_pkg::slot_none;
        win_addr = main_req.word_addr;
        if (gfx_req.req) begin
            win      = contra_rom_pkg::slot_gfx;
            win_addr = gfx_req.word_addr;
        end else if (snd_req.req) begin
            win      = contra_rom_pkg::slot_snd;
            win_addr = snd_req.word_addr;
        end else if (main_req.req) begin
            win = contra_rom_pkg::slot_main;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= contra_rom_pkg::arb_idle;
            sel       <= contra_rom_pkg::slot_none;
            sdram_req <= 1'b0;
        end else begin
            unique case (state)
                contra_rom_pkg::arb_idle: begin
                    if (win != contra_rom_pkg::slot_none) begin
                        state     <= contra_rom_pkg::arb_wait_ack;
                        sel       <= win;
                        sdram_req <= 1'b1;
                    end
                end
                contra_rom_pkg::arb_wait_ack: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= contra_rom_pkg::arb_wait_rdy;
                    end
                end
                contra_rom_pkg::arb_wait_rdy: begin
                    if (data_rdy) begin
                        state <= contra_rom_pkg::arb_idle;
                        sel   <= contra_rom_pkg::slot_none;
                    end
                end
                default: state <= contra_rom_pkg::arb_idle;
            endcase
        end
    end

    // Address only moves while idle
    always_ff @(posedge clk) begin
        if (state == contra_rom_pkg::arb_idle) sdram_addr <= win_addr;
    end

    assign rdy_hit = data_rdy && state == contra_rom_pkg::arb_wait_rdy;

    assign gfx_resp  = '{valid: rdy_hit && sel == contra_rom_pkg::slot_gfx,
                         data: data_read[15:0], spare: 1'b0};
    assign snd_resp  = '{valid: rdy_hit && sel == contra_rom_pkg::slot_snd,
                         data: data_read[15:0], spare: 1'b0};
    assign main_resp = '{valid: rdy_hit && sel == contra_rom_pkg::slot_main,
                         data: data_read[15:0], spare: 1'b0};

    a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        sdram_req && !sdram_ack |=> $stable(sdram_addr))
        else $error("sdram_addr moved before ack");

    a_one_valid: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({gfx_resp.valid, snd_resp.valid, main_resp.valid}))
        else $error("more than one slot answered");

endmodule

// File: rtl/contra_rom_pkg.sv
//==============================
// Shared ROM subsystem definitions
// SDRAM widths, slot request and response
// structs, arbiter and download enums
//==============================

package contra_rom_pkg;

    // SDRAM geometry
    localparam int sdram_aw = 22;   // 16-bit word address
    localparam int sdram_dw = 32;   // Read burst width, word in low half

    // One slot's pending read
    typedef struct packed {
        logic                req;        // Held until the answer comes back
        logic [sdram_aw-1:0] word_addr;  // Offset already added
    } rom_req_t;

    // Arbiter answer to one slot
    typedef struct packed {
        logic        valid;  // Single cycle pulse
        logic [15:0] data;
        logic        spare;  // Tied low
    } rom_resp_t;

    // Served slot, lower value wins
    typedef enum logic [1:0] {
        slot_gfx  = 2'd0,
        slot_snd  = 2'd1,
        slot_main = 2'd2,
        slot_none = 2'd3
    } slot_id_e;

    // Read arbiter FSM
    typedef enum logic [1:0] {
        arb_idle     = 2'd0,
        arb_wait_ack = 2'd1,  // sdram_req up, waiting for ack
        arb_wait_rdy = 2'd2   // Ack seen, waiting for data
    } arb_state_e;

    // Download write FSM
    typedef enum logic {
        dw_idle  = 1'b0,
        dw_write = 1'b1   // prog_we held until ack
    } dwnld_state_e;

endpackage

// File: rtl/contra_rom_slot.sv
//==============================
// ROM client slot
// One cached word, SDRAM word address,
// request to the arbiter and ok level
//==============================

`timescale 1ns/1ps

module contra_rom_slot #(
    parameter int aw = 18,
    parameter int dw = 16,   // 8 or 16
    parameter logic [contra_rom_pkg::sdram_aw-1:0] offset = '0
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cs,
    input  logic [aw-1:0]             addr,
    input  logic                      downloading,
    input  contra_rom_pkg::rom_resp_t resp,
    output contra_rom_pkg::rom_req_t  req,
    output logic [dw-1:0]             data,
    output logic                      ok
);

    logic [contra_rom_pkg::sdram_aw-1:0] word_addr;
    logic [contra_rom_pkg::sdram_aw-1:0] cache_addr;
    logic [contra_rom_pkg::sdram_aw-1:0] req_addr;
    logic [15:0]                         cache_data;
    logic                                cache_valid;
    logic                                req_on;
    logic                                hit;
    logic                                fill;

    generate
        if (dw == 16) begin : g_word
            assign word_addr = offset + {{(contra_rom_pkg::sdram_aw-aw){1'b0}}, addr};
            assign data      = cache_data;
        end else begin : g_byte
            // Two bytes per SDRAM word
            assign word_addr = offset + {{(contra_rom_pkg::sdram_aw-aw+1){1'b0}}, addr[aw-1:1]};
            assign data      = addr[0] ? cache_data[15:8] : cache_data[7:0];
        end
    endgenerate

    assign hit  = cache_valid && cache_addr == word_addr;
    assign ok   = cs && hit && !downloading;
    assign fill = req_on && resp.valid && !downloading;
    assign req  = '{req: req_on, word_addr: req_addr};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_on      <= 1'b0;
            cache_valid <= 1'b0;
        end else if (downloading) begin
            req_on      <= 1'b0;  // ROM contents are changing
            cache_valid <= 1'b0;
        end else if (req_on) begin
            if (fill) begin
                req_on      <= 1'b0;
                cache_valid <= 1'b1;
            end
        end else if (cs && !hit) begin
            req_on <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!req_on) req_addr <= word_addr;  // Frozen while the read is pending
        if (fill) begin
            cache_addr <= req_addr;
            cache_data <= resp.data;
        end
    end

endmodule

// File: rtl/contra_rom_top.sv
//==============================
// ROM subsystem top level
// Download, main map, three slots
// and the SDRAM read arbiter
//==============================

`timescale 1ns/1ps

module contra_rom_top #(
    parameter logic [21:0] gfx_offset  = 22'h01_4000,
    parameter logic [21:0] snd_offset  = 22'h01_0000,
    parameter logic [21:0] main_offset = 22'h00_0000,
    parameter logic [24:0] prom_start  = 25'h128_000
) (
    input  logic        clk,
    input  logic        rst_n,
    // Loader
    input  logic [24:0] ioctl_addr,
    input  logic [ 7:0] ioctl_data,
    input  logic        ioctl_wr,
    input  logic        downloading,
    // SDRAM
    output logic        sdram_req,
    output logic [21:0] sdram_addr,
    input  logic        sdram_ack,
    input  logic        data_rdy,
    input  logic [31:0] data_read,
    output logic [21:0] prog_addr,
    output logic [ 7:0] prog_data,
    output logic [ 1:0] prog_mask,
    output logic        prog_we,
    output logic        prom_we,
    // Clients
    input  logic        gfx_cs,
    input  logic [17:0] gfx_addr,
    output logic [15:0] gfx_data,
    output logic        gfx_ok,
    input  logic        snd_cs,
    input  logic [14:0] snd_addr,
    output logic [ 7:0] snd_data,
    output logic        snd_ok,
    input  logic [15:0] cpu_addr,
    input  logic [ 7:0] cpu_dout,
    input  logic        bank_we,
    input  logic        cpu_rd,
    output logic [ 7:0] main_data,
    output logic        main_ok
);

    contra_rom_pkg::rom_req_t  gfx_req, snd_req, main_req;
    contra_rom_pkg::rom_resp_t gfx_resp, snd_resp, main_resp;
    logic [17:0]               main_addr;
    logic                      main_cs;

    contra_dwnld #(.prom_start(prom_start)) u_dwnld (
        .clk(clk), .rst_n(rst_n), .downloading(downloading),
        .ioctl_addr(ioctl_addr), .ioctl_data(ioctl_data), .ioctl_wr(ioctl_wr),
        .sdram_ack(sdram_ack), .prog_addr(prog_addr), .prog_data(prog_data),
        .prog_mask(prog_mask), .prog_we(prog_we), .prom_we(prom_we)
    );

    contra_main_map u_map (
        .clk(clk), .rst_n(rst_n), .cpu_addr(cpu_addr), .cpu_dout(cpu_dout),
        .bank_we(bank_we), .cpu_rd(cpu_rd), .rom_addr(main_addr), .rom_cs(main_cs)
    );

    contra_rom_slot #(.aw(18), .dw(16), .offset(gfx_offset)) u_gfx (
        .clk(clk), .rst_n(rst_n), .cs(gfx_cs), .addr(gfx_addr), .downloading(downloading),
        .resp(gfx_resp), .req(gfx_req), .data(gfx_data), .ok(gfx_ok)
    );

    contra_rom_slot #(.aw(15), .dw(8), .offset(snd_offset)) u_snd (
        .clk(clk), .rst_n(rst_n), .cs(snd_cs), .addr(snd_addr), .downloading(downloading),
        .resp(snd_resp), .req(snd_req), .data(snd_data), .ok(snd_ok)
    );

    contra_rom_slot #(.aw(18), .dw(8), .offset(main_offset)) u_main (
        .clk(clk), .rst_n(rst_n), .cs(main_cs), .addr(main_addr), .downloading(downloading),
        .resp(main_resp), .req(main_req), .data(main_data), .ok(main_ok)
    );

    contra_rom_arb u_arb (
        .clk(clk), .rst_n(rst_n),
        .gfx_req(gfx_req), .snd_req(snd_req), .main_req(main_req),
        .sdram_ack(sdram_ack), .data_rdy(data_rdy), .data_read(data_read),
        .gfx_resp(gfx_resp), .snd_resp(snd_resp), .main_resp(main_resp),
        .sdram_req(sdram_req), .sdram_addr(sdram_addr)
    );

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module contra_rom_tb \
    -f list.f -o contra_rom_sim \
    && ./obj_dir/contra_rom_sim \
    || exit 1

// File: verification/contra_rom_check.svh
//==============================
// Reference ROM contents, expected
// slot values and the value check
//==============================

`ifndef contra_rom_check_svh
`define contra_rom_check_svh

// Fixed mix of every address bit, stands in for the ROM image
function automatic logic [15:0] ref_word(input logic [21:0] wa);
    logic [31:0] x;
    x = {10'd0, wa} * 32'h0000_9e37;
    x = x ^ {wa[9:0], wa};
    return x[15:0] ^ x[31:16];
endfunction

function automatic logic [7:0] pick_byte(input logic [15:0] w, input logic hi);
    return hi ? w[15:8] : w[7:0];  // Odd byte is the high half
endfunction

function automatic logic [15:0] gfx_expect(input logic [17:0] ga);
    return ref_word(gfx_offset + {4'd0, ga});
endfunction

function automatic logic [7:0] snd_expect(input logic [14:0] sa);
    return pick_byte(ref_word(snd_offset + {8'd0, sa[14:1]}), sa[0]);
endfunction

// Main CPU map, fixed 32kB then 8kB pages
function automatic logic [17:0] map_addr(input logic [15:0] ca, input logic [3:0] bk);
    if (ca[15]) return {3'b000, ca[14:0]};
    return {1'b1, bk, ca[12:0]};
endfunction

function automatic logic [7:0] main_expect(input logic [15:0] ca, input logic [3:0] bk);
    logic [17:0] ra;
    ra = map_addr(ca, bk);
    return pick_byte(ref_word(main_offset + {5'd0, ra[17:1]}), ra[0]);
endfunction

task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("[FAIL] t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        $display("sim failed");
        $fatal(1, "value mismatch on %s", name);
    end
endtask

`endif

// File: verification/contra_rom_tb.sv
//==============================
// ROM subsystem testbench
// Clock, reset, SDRAM and loader models,
// stimulus phases and timeout
//==============================

`timescale 1ns/1ps

module contra_rom_tb;

    localparam logic [21:0] gfx_offset  = 22'h01_4000;
    localparam logic [21:0] snd_offset  = 22'h01_0000;
    localparam logic [21:0] main_offset = 22'h00_0000;
    localparam logic [24:0] prom_start  = 25'h128_000;
    localparam int          max_cycles  = 20000;  // About 60 reads and 40 loads of up to 10 cycles

    logic        clk = 1'b0;
    logic        rst_n, ioctl_wr, downloading, sdram_req, sdram_ack, data_rdy;
    logic [24:0] ioctl_addr;
    logic [ 7:0] ioctl_data, prog_data, snd_data, cpu_dout, main_data;
    logic [21:0] sdram_addr, prog_addr;
    logic [31:0] data_read;
    logic [ 1:0] prog_mask;
    logic        prog_we, prom_we, gfx_cs, gfx_ok, snd_cs, snd_ok, bank_we, cpu_rd, main_ok;
    logic [17:0] gfx_addr;
    logic [15:0] gfx_data, cpu_addr;
    logic [14:0] snd_addr;
    logic [ 3:0] bank = 4'd0;  // Mirror of the DUT bank register
    logic        quiet = 1'b0;
    int          cycles = 0;

    `include "contra_rom_check.svh"

    contra_rom_top #(.gfx_offset(gfx_offset), .snd_offset(snd_offset),
                     .main_offset(main_offset), .prom_start(prom_start)) DUT (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout: test still running after %0d cycles", cycles);
            $display("sim failed");
            $fatal(1, "timeout");
        end
    end

    always @(negedge clk) begin
        if (downloading) begin  // No ROM data while loading
            check_eq("gfx_ok", gfx_ok, 0);
            check_eq("snd_ok", snd_ok, 0);
            check_eq("main_ok", main_ok, 0);
        end
        if (quiet) check_eq("sdram_req", sdram_req, 0);
    end

    task automatic tick;
        @(posedge clk);
        #1;
    endtask

    function automatic logic ok_of(input int which);
        return which == 0 ? gfx_ok : which == 1 ? snd_ok : main_ok;
    endfunction

    task automatic wait_ok(input int which);
        @(negedge clk);
        while (!ok_of(which)) @(negedge clk);
    endtask

    task automatic wait_all;
        @(negedge clk);
        while (!(gfx_ok && snd_ok && main_ok)) @(negedge clk);
    endtask

    // SDRAM controller model with one ack for reads and writes
    initial begin : sdram_model
        logic [21:0] rd_addr;
        logic        is_rd;
        int          wait_n;
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        forever begin
            tick;
            if (rst_n && (sdram_req || prog_we)) begin
                is_rd   = sdram_req;
                rd_addr = sdram_addr;
                wait_n  = 1 + $urandom % 4;
                repeat (wait_n - 1) begin
                    tick;
                    if (is_rd) begin
                        check_eq("sdram_req", sdram_req, 1);  // Held until ack
                        check_eq("sdram_addr", sdram_addr, rd_addr);
                    end else begin
                        check_eq("prog_we", prog_we, 1);
                    end
                end
                sdram_ack = 1'b1;
                tick;
                sdram_ack = 1'b0;
                if (!is_rd) begin
                    check_eq("prog_we", prog_we, 0);
                end else begin
                    check_eq("sdram_req", sdram_req, 0);
                    tick;
                    data_rdy  = 1'b1;
                    data_read = ($urandom << 16) | ref_word(rd_addr);
                    tick;
                    data_rdy  = 1'b0;
                end
            end
        end
    end

    task automatic load_byte(input logic [24:0] a, input logic [7:0] d);
        logic [24:0] off;
        off        = a - prom_start;
        ioctl_addr = a;
        ioctl_data = d;
        ioctl_wr   = 1'b1;
        tick;
        ioctl_wr = 1'b0;
        check_eq("prog_data", prog_data, d);
        if (a >= prom_start) begin
            check_eq("prom_we", prom_we, 1);
            check_eq("prog_we", prog_we, 0);
            check_eq("prog_addr", prog_addr, off[21:0]);
            tick;
            check_eq("prom_we", prom_we, 0);  // Single pulse
        end else begin
            check_eq("prog_we", prog_we, 1);
            check_eq("prom_we", prom_we, 0);
            check_eq("prog_addr", prog_addr, a[22:1]);
            check_eq("prog_mask", prog_mask, a[0] ? 2'b01 : 2'b10);
            while (prog_we) tick;
        end
    endtask

    task automatic read_main(input logic [15:0] ca);
        cpu_addr = ca;
        wait_ok(2);
        check_eq("main_data", main_data, main_expect(ca, bank));
        tick;
    endtask

    initial begin : stimulus
        logic [17:0] ga;
        logic [14:0] sa;
        logic [15:0] ca;
        int          k;
        void'($urandom(32'h903bfd8a));
        rst_n = 1'b0;
        ioctl_addr = '0;
        ioctl_data = '0;
        ioctl_wr = 1'b0;
        downloading = 1'b0;
        gfx_cs = 1'b0;
        gfx_addr = '0;
        snd_cs = 1'b0;
        snd_addr = '0;
        cpu_addr = '0;
        cpu_dout = '0;
        bank_we = 1'b0;
        cpu_rd = 1'b0;
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;
        check_eq("sdram_req", sdram_req, 0);
        check_eq("prog_we", prog_we, 0);
        check_eq("prom_we", prom_we, 0);

        downloading = 1'b1;
        repeat (24) load_byte($urandom % prom_start, $urandom);
        repeat (4) load_byte(prom_start + $urandom % 25'h8000, $urandom);
        downloading = 1'b0;

        gfx_cs = 1'b1;
        repeat (12) begin
            ga = $urandom;
            gfx_addr = ga;
            wait_ok(0);
            check_eq("gfx_data", gfx_data, gfx_expect(ga));
            tick;
        end
        gfx_cs = 1'b0;

        snd_cs = 1'b1;
        repeat (12) begin
            sa = $urandom;
            snd_addr = sa;
            wait_ok(1);
            check_eq("snd_data", snd_data, snd_expect(sa));
            repeat (4) begin  // Same address stays a hit
                tick;
                @(negedge clk);
                check_eq("snd_ok", snd_ok, 1);
                check_eq("sdram_req", sdram_req, 0);
            end
            tick;
        end
        snd_cs = 1'b0;

        repeat (4) begin
            cpu_dout = $urandom;
            bank     = cpu_dout[3:0];
            bank_we  = 1'b1;
            tick;
            bank_we = 1'b0;
            cpu_rd  = 1'b1;
            repeat (3) begin
                ca = $urandom;
                ca[15] = 1'b1;
                read_main(ca);
                ca = $urandom;
                ca[15:13] = 3'b011;
                read_main(ca);
            end
            cpu_rd = 1'b0;
        end
        ca = $urandom;
        ca[15:13] = 3'b010;  // Neither window
        cpu_addr = ca;
        cpu_rd   = 1'b1;
        repeat (20) begin
            @(negedge clk);
            check_eq("main_ok", main_ok, 0);
        end
        tick;

        repeat (2) begin
            ga = $urandom;
            sa = $urandom;
            ca = $urandom;
            ca[15] = 1'b1;
            gfx_addr = ga;
            snd_addr = sa;
            cpu_addr = ca;
            gfx_cs = 1'b1;
            snd_cs = 1'b1;
            tick;
            downloading = 1'b1;  // Arrives with requests pending
            k = 0;
            while (k < 4) begin  // Let the read in flight finish
                tick;
                k = sdram_req ? 0 : k + 1;
            end
            quiet = 1'b1;
            repeat (6) load_byte($urandom % prom_start, $urandom);
            load_byte(prom_start + $urandom % 25'h8000, $urandom);
            quiet = 1'b0;
            downloading = 1'b0;
            wait_all;
            check_eq("gfx_data", gfx_data, gfx_expect(ga));
            check_eq("snd_data", snd_data, snd_expect(sa));
            check_eq("main_data", main_data, main_expect(ca, bank));
            tick;
        end

        $display("sim passed");
        $finish;
    end

endmodule
